/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = alu_tb
FILELIST  = verilog.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
PASS_MSG  = Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(BIN) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* logic/alu_consts.svh */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result width
`define ALU_DATA_W 64

// 32-bit operand size, results zero-extended above it
`define ALU_HALF_W 32

`define ALU_AUX_BIT 4 // carry into this bit is the aux carry

// c, o, a, s, z, p
`define ALU_FLAG_W 6

`define ALU_OP_W 3
`define ALU_COND_W 4

`endif

/* logic/alu_datapath.sv */
`include "alu_consts.svh"

module alu_datapath (
  input  alu_pkg::alu_uop_t  uop,
  input  alu_pkg::alu_data_t val1,
  input  alu_pkg::alu_data_t val2,
  output alu_pkg::alu_raw_t  raw
);

  logic                 is_sub;
  alu_pkg::alu_data_t   opb;
  logic [`ALU_DATA_W:0] sum;
  logic                 carry_half;
  logic                 carry_aux;
  alu_pkg::alu_data_t   res;

  assign is_sub = (uop.op == alu_pkg::op_sub);

  // one adder for both, sub is val1 + ~val2 + 1
  assign opb = is_sub ? ~val2 : val2;
  assign sum = {1'b0, val1} + {1'b0, opb} + {{`ALU_DATA_W{1'b0}}, is_sub};

  // carry into a bit is its sum bit xor both operand bits
  assign carry_half = sum[`ALU_HALF_W] ^ val1[`ALU_HALF_W] ^ opb[`ALU_HALF_W];
  assign carry_aux  = sum[`ALU_AUX_BIT] ^ val1[`ALU_AUX_BIT] ^ opb[`ALU_AUX_BIT];

  always_comb begin
    case (uop.op)
      alu_pkg::op_add,
      alu_pkg::op_sub: res = sum[`ALU_DATA_W-1:0];
      alu_pkg::op_and: res = val1 & val2;
      alu_pkg::op_or:  res = val1 | val2;
      alu_pkg::op_xor: res = val1 ^ val2;
      alu_pkg::op_mov: res = val2;
      // cmov/cset are resolved in writeback
      default:         res = '0;
    endcase
  end

  always_comb begin
    if (uop.is64) begin
      raw.value = res;
      raw.carry = sum[`ALU_DATA_W];
    end else begin
      raw.value = {{(`ALU_DATA_W-`ALU_HALF_W){1'b0}}, res[`ALU_HALF_W-1:0]};
      raw.carry = carry_half;
    end
    raw.aux = carry_aux;
  end

endmodule

/* logic/alu_pkg.sv */
`include "alu_consts.svh"

package alu_pkg;

  typedef logic [`ALU_DATA_W-1:0] alu_data_t;

  // same bit order as the flag register, c in the msb
  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } alu_flags_t;

  typedef enum logic [`ALU_OP_W-1:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_mov,
    op_cmov,
    op_cset
  } alu_op_e;

  // odd code is the inverse of the even one below it
  typedef enum logic [`ALU_COND_W-1:0] {
    cc_z,   cc_nz,
    cc_s,   cc_ns,
    cc_ugt, cc_ule,
    cc_uge, cc_ult,
    cc_sgt, cc_sle,
    cc_sge, cc_slt,
    cc_o,   cc_no,
    cc_p,   cc_np
  } alu_cond_e;

  typedef struct packed {
    alu_op_e   op;
    logic      is64;
    logic      set_flags;
    alu_cond_e cond;
  } alu_uop_t;

  typedef struct packed {
    alu_data_t value;
    logic      carry; // out of bit 63 or 31
    logic      aux;
  } alu_raw_t;

  typedef struct packed {
    alu_data_t  result;
    alu_flags_t flags;
    logic       sets_flags;
  } alu_ret_t;

endpackage

/* logic/alu_top.sv */
module alu_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  input  alu_pkg::alu_uop_t   uop,
  input  alu_pkg::alu_data_t  val1,
  input  alu_pkg::alu_data_t  val2,
  input  alu_pkg::alu_flags_t flags_in,
  output logic                ret_en,
  output alu_pkg::alu_ret_t   ret
);

  alu_pkg::alu_raw_t raw;
  logic              taken;

  alu_datapath alu_datapath_inst (
    .uop  (uop),
    .val1 (val1),
    .val2 (val2),
    .raw  (raw)
  );

  // condition on the incoming flags, for cmov/cset
  cond_eval cond_eval_inst (
    .cond  (uop.cond),
    .flags (flags_in),
    .taken (taken)
  );

  alu_writeback alu_writeback_inst (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .uop    (uop),
    .val1   (val1),
    .val2   (val2),
    .raw    (raw),
    .taken  (taken),
    .ret_en (ret_en),
    .ret    (ret)
  );

endmodule

/* logic/alu_writeback.sv */
`include "alu_consts.svh"

module alu_writeback (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  alu_pkg::alu_uop_t  uop,
  input  alu_pkg::alu_data_t val1,
  input  alu_pkg::alu_data_t val2,
  input  alu_pkg::alu_raw_t  raw,
  input  logic               taken,
  output logic               ret_en,
  output alu_pkg::alu_ret_t  ret
);

  alu_pkg::alu_data_t       value;
  alu_pkg::alu_data_t       moved;
  logic                     sign1;
  logic                     sign2;

  alu_pkg::alu_data_t       res_q;
  alu_pkg::alu_op_e         op_q;
  logic                     is64_q;
  logic                     set_flags_q;
  logic                     carry_q;
  logic                     aux_q;
  logic                     sign1_q;
  logic                     sign2_q;
  logic                     en_q;

  logic                     sign_r;
  logic                     zero_r;
  logic                     parity_r;
  logic                     add_of;
  logic                     sub_of;
  logic [`ALU_FLAG_W-1:0]   flag_bits;

  assign moved = taken ? val2 : val1;

  always_comb begin
    case (uop.op)
      alu_pkg::op_cmov: value = uop.is64 ? moved :
        {{(`ALU_DATA_W-`ALU_HALF_W){1'b0}}, moved[`ALU_HALF_W-1:0]};
      alu_pkg::op_cset: value = {{(`ALU_DATA_W-1){1'b0}}, taken};
      default:          value = raw.value;
    endcase
  end

  assign sign1 = uop.is64 ? val1[`ALU_DATA_W-1] : val1[`ALU_HALF_W-1];
  assign sign2 = uop.is64 ? val2[`ALU_DATA_W-1] : val2[`ALU_HALF_W-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q        <= 1'b0;
      res_q       <= '0;
      op_q        <= alu_pkg::op_mov; // mov returns all-zero flags
      is64_q      <= 1'b0;
      set_flags_q <= 1'b0;
      carry_q     <= 1'b0;
      aux_q       <= 1'b0;
      sign1_q     <= 1'b0;
      sign2_q     <= 1'b0;
    end else begin
      en_q <= en;
      if (en) begin // hold last return otherwise
        res_q       <= value;
        op_q        <= uop.op;
        is64_q      <= uop.is64;
        set_flags_q <= uop.set_flags;
        carry_q     <= raw.carry;
        aux_q       <= raw.aux;
        sign1_q     <= sign1;
        sign2_q     <= sign2;
      end
    end
  end

  // flags from the registered result
  assign sign_r   = is64_q ? res_q[`ALU_DATA_W-1] : res_q[`ALU_HALF_W-1];
  assign zero_r   = is64_q ? (res_q == '0) : (res_q[`ALU_HALF_W-1:0] == '0);
  assign parity_r = ~^res_q[7:0];
  assign add_of   = (sign1_q == sign2_q) & (sign_r != sign1_q);
  assign sub_of   = (sign1_q != sign2_q) & (sign_r != sign1_q);

  always_comb begin
    case (op_q)
      alu_pkg::op_add: flag_bits = {carry_q, add_of, aux_q, sign_r, zero_r, parity_r};
      alu_pkg::op_sub: flag_bits = {~carry_q, sub_of, ~aux_q, sign_r, zero_r, parity_r};
      alu_pkg::op_and,
      alu_pkg::op_or,
      alu_pkg::op_xor: flag_bits = {3'b000, sign_r, zero_r, parity_r};
      default:         flag_bits = '0;
    endcase
  end

  assign ret_en         = en_q;
  assign ret.result     = res_q;
  assign ret.flags      = alu_pkg::alu_flags_t'(flag_bits);
  assign ret.sets_flags = set_flags_q & (op_q inside {alu_pkg::op_add, alu_pkg::op_sub,
                                                      alu_pkg::op_and, alu_pkg::op_or,
                                                      alu_pkg::op_xor});

endmodule

/* logic/cond_eval.sv */
module cond_eval (
  input  alu_pkg::alu_cond_e  cond,
  input  alu_pkg::alu_flags_t flags,
  output logic                taken
);

  logic s_ne_o;

  assign s_ne_o = flags.s ^ flags.o; // signed less-than

  always_comb begin
    case (cond)
      alu_pkg::cc_z:   taken = flags.z;
      alu_pkg::cc_nz:  taken = ~flags.z;
      alu_pkg::cc_s:   taken = flags.s;
      alu_pkg::cc_ns:  taken = ~flags.s;
      alu_pkg::cc_ugt: taken = ~(flags.c | flags.z);
      alu_pkg::cc_ule: taken = flags.c | flags.z;
      alu_pkg::cc_uge: taken = ~flags.c;
      alu_pkg::cc_ult: taken = flags.c;
      alu_pkg::cc_sgt: taken = ~(s_ne_o | flags.z);
      alu_pkg::cc_sle: taken = s_ne_o | flags.z;
      alu_pkg::cc_sge: taken = ~s_ne_o;
      alu_pkg::cc_slt: taken = s_ne_o;
      alu_pkg::cc_o:   taken = flags.o;
      alu_pkg::cc_no:  taken = ~flags.o;
      alu_pkg::cc_p:   taken = flags.p;
      alu_pkg::cc_np:  taken = ~flags.p;
      default:         taken = 1'b0;
    endcase
  end

endmodule

/* verification/alu_properties.sv */
module alu_properties (
  input logic                clk,
  input logic                rst,
  input logic                en,
  input alu_pkg::alu_uop_t   uop,
  input logic                ret_en,
  input alu_pkg::alu_ret_t   ret
);

  logic logic_op;

  assign logic_op = en && (uop.op inside {alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor});

  ret_en_follows_en: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> ret_en == $past(en))
    else $error("ret_en is not en delayed by one cycle");

  // first cycle out of reset
  ret_en_low_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !ret_en)
    else $error("ret_en high right after reset");

  logic_flags_clear: assert property (@(posedge clk) disable iff (rst)
    $past(logic_op) |-> (ret.flags.c == 1'b0 && ret.flags.o == 1'b0 && ret.flags.a == 1'b0))
    else $error("c, o or a set by a logic op");

  ret_held: assert property (@(posedge clk) disable iff (rst)
    (!ret_en && !$past(rst)) |-> $stable(ret))
    else $error("ret changed while ret_en low");

endmodule

bind alu_top alu_properties alu_properties_inst (
  .clk    (clk),
  .rst    (rst),
  .en     (en),
  .uop    (uop),
  .ret_en (ret_en),
  .ret    (ret)
);

/* verification/alu_tb.sv */
`include "alu_consts.svh"

module alu_tb;

  localparam int NUM_OPS = 2000;

  typedef struct {
    alu_pkg::alu_ret_t ret;
    alu_pkg::alu_op_e  op;
    int                due; // posedge index where ret_en should show it
  } expect_t;

  logic                clk;
  logic                rst;
  logic                en;
  alu_pkg::alu_uop_t   uop;
  alu_pkg::alu_data_t  val1;
  alu_pkg::alu_data_t  val2;
  alu_pkg::alu_flags_t flags_in;
  logic                ret_en;
  alu_pkg::alu_ret_t   ret;

  integer  seed;
  int      cycle;
  int      value_errs;
  int      proto_errs;
  int      waited;
  expect_t exp_q[$];
  expect_t cur;

  alu_top alu_top_inst (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .uop      (uop),
    .val1     (val1),
    .val2     (val2),
    .flags_in (flags_in),
    .ret_en   (ret_en),
    .ret      (ret)
  );

  always #5 clk = ~clk;

  task automatic check_result(input alu_pkg::alu_data_t got, input alu_pkg::alu_data_t exp,
                              input string what);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s result %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input alu_pkg::alu_flags_t got, input alu_pkg::alu_flags_t exp,
                             input string what);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s flags coaszp %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_sets(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // codes come in pairs, odd one inverted
  function automatic logic cond_taken(alu_pkg::alu_cond_e c, alu_pkg::alu_flags_t f);
    logic [3:0] code;
    logic       base;
    code = c;
    case (code[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.s;
      3'd2:    base = !f.c && !f.z; // unsigned above
      3'd3:    base = !f.c;
      3'd4:    base = (f.s == f.o) && !f.z;
      3'd5:    base = (f.s == f.o);
      3'd6:    base = f.o;
      default: base = f.p;
    endcase
    return base ^ code[0];
  endfunction

  function automatic alu_pkg::alu_ret_t expected_return(alu_pkg::alu_uop_t u,
      alu_pkg::alu_data_t a, alu_pkg::alu_data_t b, alu_pkg::alu_flags_t f);
    alu_pkg::alu_data_t   mask;
    alu_pkg::alu_data_t   res;
    logic [`ALU_DATA_W:0] wide;
    logic [`ALU_HALF_W:0] narrow;
    logic [4:0]           nib;
    logic                 sa;
    logic                 sb;
    logic                 sr;
    logic                 tk;
    alu_pkg::alu_ret_t    r;
    mask = u.is64 ? '1 : {{`ALU_HALF_W{1'b0}}, {`ALU_HALF_W{1'b1}}};
    sa = u.is64 ? a[`ALU_DATA_W-1] : a[`ALU_HALF_W-1];
    sb = u.is64 ? b[`ALU_DATA_W-1] : b[`ALU_HALF_W-1];
    tk = cond_taken(u.cond, f);
    r = '0;
    case (u.op)
      alu_pkg::op_add: begin
        wide = {1'b0, a} + {1'b0, b};
        narrow = {1'b0, a[`ALU_HALF_W-1:0]} + {1'b0, b[`ALU_HALF_W-1:0]};
        nib = {1'b0, a[3:0]} + {1'b0, b[3:0]};
        r.flags.a = nib[4];
        r.flags.c = u.is64 ? wide[`ALU_DATA_W] : narrow[`ALU_HALF_W];
        res = wide[`ALU_DATA_W-1:0];
      end
      alu_pkg::op_sub: begin
        wide = {1'b0, a} - {1'b0, b}; // top bit is the borrow
        narrow = {1'b0, a[`ALU_HALF_W-1:0]} - {1'b0, b[`ALU_HALF_W-1:0]};
        r.flags.a = (a[3:0] < b[3:0]);
        r.flags.c = u.is64 ? wide[`ALU_DATA_W] : narrow[`ALU_HALF_W];
        res = wide[`ALU_DATA_W-1:0];
      end
      alu_pkg::op_and:  res = a & b;
      alu_pkg::op_or:   res = a | b;
      alu_pkg::op_xor:  res = a ^ b;
      alu_pkg::op_cmov: res = tk ? b : a;
      alu_pkg::op_cset: res = {{(`ALU_DATA_W-1){1'b0}}, tk};
      default:          res = b;
    endcase
    res = res & mask;
    sr = u.is64 ? res[`ALU_DATA_W-1] : res[`ALU_HALF_W-1];
    if (u.op inside {alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_and, alu_pkg::op_or,
                     alu_pkg::op_xor}) begin
      if (u.op == alu_pkg::op_add)
        r.flags.o = (sa == sb) && (sr != sa);
      else if (u.op == alu_pkg::op_sub)
        r.flags.o = (sa != sb) && (sr != sa);
      r.flags.s = sr;
      r.flags.z = (res == '0);
      r.flags.p = ($countones(res[7:0]) % 2) == 0;
      r.sets_flags = u.set_flags;
    end
    r.result = res;
    return r;
  endfunction

  // boundary values to provoke carries and overflow
  function automatic alu_pkg::alu_data_t pick_operand();
    logic [31:0] sel;
    sel = $random(seed);
    case (sel[2:0])
      3'd0:    return '0;
      3'd1:    return '1;
      3'd2:    return 64'h8000_0000_0000_0000;
      3'd3:    return 64'h7fff_ffff_ffff_ffff;
      3'd4:    return 64'h0000_0000_8000_0000;
      3'd5:    return 64'h0000_0000_7fff_ffff;
      3'd6:    return {{(`ALU_DATA_W-8){1'b0}}, sel[15:8]};
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  task automatic drive_random();
    logic [31:0] rnd;
    expect_t     entry;
    rnd = $random(seed);
    en = (rnd[1:0] != 2'b00);
    uop.op = alu_pkg::alu_op_e'(rnd[4:2]);
    uop.is64 = rnd[5];
    uop.set_flags = rnd[6];
    uop.cond = alu_pkg::alu_cond_e'(rnd[10:7]);
    flags_in = alu_pkg::alu_flags_t'(rnd[16:11]);
    val1 = pick_operand();
    val2 = pick_operand();
    if (en) begin
      entry.ret = expected_return(uop, val1, val2, flags_in);
      entry.op = uop.op;
      entry.due = cycle + 2;
      exp_q.push_back(entry);
    end
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (!rst) begin
      if (ret_en) begin
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("ret_en was high at time %0t with no operation outstanding", $time);
        end else begin
          cur = exp_q.pop_front();
          if (cur.due != cycle) begin
            proto_errs++;
            $display("%s return came at cycle %0d instead of %0d", cur.op.name(), cycle,
                     cur.due);
          end
          check_result(ret.result, cur.ret.result, cur.op.name());
          check_flags(ret.flags, cur.ret.flags, cur.op.name());
          check_sets(ret.sets_flags, cur.ret.sets_flags, "sets_flags");
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
        cur = exp_q.pop_front();
        proto_errs++;
        $display("the %s return due at cycle %0d never arrived", cur.op.name(), cur.due);
      end
    end
  end

  initial begin
    seed = 32'h038a_6336;
    clk = 1'b0;
    rst = 1'b1;
    en = 1'b0;
    uop = '0;
    val1 = '0;
    val2 = '0;
    flags_in = '0;
    cycle = 0;
    value_errs = 0;
    proto_errs = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    check_sets(ret_en, 1'b0, "ret_en after reset");
    check_result(ret.result, '0, "reset");
    check_flags(ret.flags, '0, "reset");
    check_sets(ret.sets_flags, 1'b0, "sets_flags after reset");
    rst = 1'b0;
    for (int i = 0; i < NUM_OPS; i++) begin
      drive_random();
      @(negedge clk);
    end
    en = 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      proto_errs += exp_q.size();
      $display("%0d expected returns were still outstanding at the end", exp_q.size());
    end
    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+logic
logic/alu_pkg.sv
logic/alu_datapath.sv
logic/cond_eval.sv
logic/alu_writeback.sv
logic/alu_top.sv
verification/alu_properties.sv
verification/alu_tb.sv
